// File: include/decodeExecute_params.svh
`ifndef DECODE_EXECUTE_PARAMS_SVH
`define DECODE_EXECUTE_PARAMS_SVH

// Width of data words and instruction words
`define DataWidth 32

// Width of a register number
`define RegAddrWidth 5

// Number of architectural registers, register 0 included
`define RegCount 32

`endif

// File: source/DecodeExecutePkg.sv
package DecodeExecutePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpAddiu   = 6'h09,
        OpAndi    = 6'h0c,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f
    } OpcodeE;

    // Function code of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2a
    } FunctE;

    ////////////////////////////////////////////////////////////////////////////
    // Execute controls
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        AluAdd = 4'd0,
        AluSub = 4'd1,
        AluAnd = 4'd2,
        AluOr  = 4'd3,
        AluXor = 4'd4,
        AluSlt = 4'd5,
        AluSll = 4'd6,
        AluSrl = 4'd7,
        AluLui = 4'd8
    } AluOpE;

endpackage

// File: source/InstructionDecoder.sv
`include "decodeExecute_params.svh"

module InstructionDecoder (
    input  logic                     InstrValid,
    input  logic [`DataWidth-1:0]    InstrWord,
    output logic [`RegAddrWidth-1:0] RsAddr,
    output logic [`RegAddrWidth-1:0] RtAddr,
    output logic                     RegWrite,
    output logic                     AluSrc,
    output DecodeExecutePkg::AluOpE  AluOp,
    output logic [`RegAddrWidth-1:0] DestReg,
    output logic [`RegAddrWidth-1:0] Shamt,
    output logic [`DataWidth-1:0]    Imm
);

    DecodeExecutePkg::OpcodeE opcode;
    DecodeExecutePkg::FunctE  funct;
    logic [`RegAddrWidth-1:0] rdAddr;
    logic [15:0]              imm16;
    logic                     supported;

    // Instruction fields
    assign opcode = DecodeExecutePkg::OpcodeE'(InstrWord[31:26]);
    assign funct  = DecodeExecutePkg::FunctE'(InstrWord[5:0]);
    assign RsAddr = InstrWord[25:21];
    assign RtAddr = InstrWord[20:16];
    assign rdAddr = InstrWord[15:11];
    assign Shamt  = InstrWord[10:6];
    assign imm16  = InstrWord[15:0];

    always_comb begin
        // I-type defaults: rt is the destination, immediate as operand B
        supported = 1'b1;
        AluSrc    = 1'b1;
        AluOp     = DecodeExecutePkg::AluAdd;
        DestReg   = RtAddr;
        Imm       = {{(`DataWidth-16){1'b0}}, imm16};
        case (opcode)
            DecodeExecutePkg::OpSpecial: begin
                AluSrc  = 1'b0;
                DestReg = rdAddr;
                case (funct)
                    DecodeExecutePkg::FnSll:  AluOp = DecodeExecutePkg::AluSll;
                    DecodeExecutePkg::FnSrl:  AluOp = DecodeExecutePkg::AluSrl;
                    DecodeExecutePkg::FnAddu: AluOp = DecodeExecutePkg::AluAdd;
                    DecodeExecutePkg::FnSubu: AluOp = DecodeExecutePkg::AluSub;
                    DecodeExecutePkg::FnAnd:  AluOp = DecodeExecutePkg::AluAnd;
                    DecodeExecutePkg::FnOr:   AluOp = DecodeExecutePkg::AluOr;
                    DecodeExecutePkg::FnXor:  AluOp = DecodeExecutePkg::AluXor;
                    DecodeExecutePkg::FnSlt:  AluOp = DecodeExecutePkg::AluSlt;
                    default:                  supported = 1'b0;
                endcase
            end
            DecodeExecutePkg::OpAddiu: begin
                // Only ADDIU sign-extends
                AluOp = DecodeExecutePkg::AluAdd;
                Imm   = {{(`DataWidth-16){imm16[15]}}, imm16};
            end
            DecodeExecutePkg::OpAndi: AluOp = DecodeExecutePkg::AluAnd;
            DecodeExecutePkg::OpOri:  AluOp = DecodeExecutePkg::AluOr;
            DecodeExecutePkg::OpLui:  AluOp = DecodeExecutePkg::AluLui;
            default:                  supported = 1'b0;
        endcase
    end

    // Anything not valid or not supported turns into a bubble
    assign RegWrite = InstrValid && supported;

endmodule

// File: source/RegisterFile.sv
`include "decodeExecute_params.svh"

module RegisterFile (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic [`RegAddrWidth-1:0] RsAddr,
    input  logic [`RegAddrWidth-1:0] RtAddr,
    output logic [`DataWidth-1:0]    RsData,
    output logic [`DataWidth-1:0]    RtData,
    input  logic                     WrEn,
    input  logic [`RegAddrWidth-1:0] WrAddr,
    input  logic [`DataWidth-1:0]    WrData
);

    // Register 0 has no storage and always reads as zero
    logic [`DataWidth-1:0] regs [1:`RegCount-1];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (WrEn && (WrAddr != '0)) begin
            regs[WrAddr] <= WrData;
        end
    end

    // Reads see a write of the same cycle
    always_comb begin
        if (RsAddr == '0) begin
            RsData = '0;
        end else if (WrEn && (WrAddr == RsAddr)) begin
            RsData = WrData;
        end else begin
            RsData = regs[RsAddr];
        end
        if (RtAddr == '0) begin
            RtData = '0;
        end else if (WrEn && (WrAddr == RtAddr)) begin
            RtData = WrData;
        end else begin
            RtData = regs[RtAddr];
        end
    end

endmodule

// File: source/IdExReg.sv
`include "decodeExecute_params.svh"

module IdExReg (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     WriteEnable,
    // Decode side
    input  logic                     RegWriteIn,
    input  logic                     AluSrcIn,
    input  DecodeExecutePkg::AluOpE  AluOpIn,
    input  logic [`RegAddrWidth-1:0] DestRegIn,
    input  logic [`RegAddrWidth-1:0] ShamtIn,
    input  logic [`DataWidth-1:0]    ImmIn,
    input  logic [`RegAddrWidth-1:0] RsRegIn,
    input  logic [`RegAddrWidth-1:0] RtRegIn,
    input  logic [`DataWidth-1:0]    RsDataIn,
    input  logic [`DataWidth-1:0]    RtDataIn,
    input  logic [`DataWidth-1:0]    CountIn,
    // Execute side
    output logic                     RegWriteOut,
    output logic                     AluSrcOut,
    output DecodeExecutePkg::AluOpE  AluOpOut,
    output logic [`RegAddrWidth-1:0] DestRegOut,
    output logic [`RegAddrWidth-1:0] ShamtOut,
    output logic [`DataWidth-1:0]    ImmOut,
    output logic [`RegAddrWidth-1:0] RsRegOut,
    output logic [`RegAddrWidth-1:0] RtRegOut,
    output logic [`DataWidth-1:0]    RsDataOut,
    output logic [`DataWidth-1:0]    RtDataOut,
    output logic [`DataWidth-1:0]    CountOut
);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            RegWriteOut <= 1'b0;
            AluSrcOut   <= 1'b0;
            AluOpOut    <= DecodeExecutePkg::AluAdd;
            DestRegOut  <= '0;
            ShamtOut    <= '0;
            ImmOut      <= '0;
            RsRegOut    <= '0;
            RtRegOut    <= '0;
            RsDataOut   <= '0;
            RtDataOut   <= '0;
            CountOut    <= '0;
        end else if (WriteEnable) begin
            // Hold everything while the pipeline is stalled
            RegWriteOut <= RegWriteIn;
            AluSrcOut   <= AluSrcIn;
            AluOpOut    <= AluOpIn;
            DestRegOut  <= DestRegIn;
            ShamtOut    <= ShamtIn;
            ImmOut      <= ImmIn;
            RsRegOut    <= RsRegIn;
            RtRegOut    <= RtRegIn;
            RsDataOut   <= RsDataIn;
            RtDataOut   <= RtDataIn;
            CountOut    <= CountIn;
        end
    end

endmodule

// File: source/ExecuteUnit.sv
`include "decodeExecute_params.svh"

module ExecuteUnit (
    input  logic                     RegWriteIn,
    input  logic                     AluSrc,
    input  DecodeExecutePkg::AluOpE  AluOp,
    input  logic [`RegAddrWidth-1:0] DestRegIn,
    input  logic [`RegAddrWidth-1:0] Shamt,
    input  logic [`DataWidth-1:0]    Imm,
    input  logic [`RegAddrWidth-1:0] RsReg,
    input  logic [`RegAddrWidth-1:0] RtReg,
    input  logic [`DataWidth-1:0]    RsData,
    input  logic [`DataWidth-1:0]    RtData,
    input  logic [`DataWidth-1:0]    CountIn,
    // Result stage entry, one instruction ahead
    input  logic                     FwdValid,
    input  logic [`RegAddrWidth-1:0] FwdReg,
    input  logic [`DataWidth-1:0]    FwdData,
    output logic [`DataWidth-1:0]    AluResult,
    output logic [`RegAddrWidth-1:0] DestReg,
    output logic                     RegWrite,
    output logic [`DataWidth-1:0]    Count
);

    logic [`DataWidth-1:0] operandA;
    logic [`DataWidth-1:0] rtValue;
    logic [`DataWidth-1:0] operandB;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding, register 0 excluded
    ////////////////////////////////////////////////////////////////////////////

    assign operandA = (FwdValid && (RsReg != '0) && (FwdReg == RsReg)) ? FwdData : RsData;
    assign rtValue  = (FwdValid && (RtReg != '0) && (FwdReg == RtReg)) ? FwdData : RtData;
    assign operandB = AluSrc ? Imm : rtValue;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        AluResult = '0;
        case (AluOp)
            DecodeExecutePkg::AluAdd: AluResult = operandA + operandB;
            DecodeExecutePkg::AluSub: AluResult = operandA - operandB;
            DecodeExecutePkg::AluAnd: AluResult = operandA & operandB;
            DecodeExecutePkg::AluOr:  AluResult = operandA | operandB;
            DecodeExecutePkg::AluXor: AluResult = operandA ^ operandB;
            DecodeExecutePkg::AluSlt: AluResult[0] = $signed(operandA) < $signed(operandB);
            // Shifts act on rt
            DecodeExecutePkg::AluSll: AluResult = operandB << Shamt;
            DecodeExecutePkg::AluSrl: AluResult = operandB >> Shamt;
            DecodeExecutePkg::AluLui: AluResult = operandB << 16;
            default:                  AluResult = '0;
        endcase
    end

    assign DestReg  = DestRegIn;
    assign RegWrite = RegWriteIn;
    assign Count    = CountIn;

endmodule

// File: source/ResultStage.sv
`include "decodeExecute_params.svh"

module ResultStage (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     Load,
    input  logic                     RegWriteIn,
    input  logic [`RegAddrWidth-1:0] DestIn,
    input  logic [`DataWidth-1:0]    DataIn,
    input  logic [`DataWidth-1:0]    CountIn,
    output logic                     ResultValid,
    output logic [`RegAddrWidth-1:0] ResultDest,
    output logic [`DataWidth-1:0]    ResultData,
    output logic [`DataWidth-1:0]    ResultCount,
    input  logic                     ResultReady,
    output logic                     WrEn,
    output logic [`RegAddrWidth-1:0] WrAddr,
    output logic [`DataWidth-1:0]    WrData,
    output logic                     FwdValid,
    output logic [`RegAddrWidth-1:0] FwdReg,
    output logic [`DataWidth-1:0]    FwdData
);

    // A bubble loads as an empty entry
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ResultValid <= 1'b0;
        end else if (Load) begin
            ResultValid <= RegWriteIn;
        end
    end

    always_ff @(posedge Clock) begin
        if (Load) begin
            ResultDest  <= DestIn;
            ResultData  <= DataIn;
            ResultCount <= CountIn;
        end
    end

    // Write back on the handoff edge
    assign WrEn   = ResultValid && ResultReady;
    assign WrAddr = ResultDest;
    assign WrData = ResultData;

    assign FwdValid = ResultValid;
    assign FwdReg   = ResultDest;
    assign FwdData  = ResultData;

endmodule

// File: source/DecodeExecuteCore.sv
`include "decodeExecute_params.svh"

module DecodeExecuteCore (
    input  logic                     Clock,
    input  logic                     arstN,
    input  logic                     InstrValid,
    output logic                     InstrReady,
    input  logic [`DataWidth-1:0]    InstrWord,
    input  logic [`DataWidth-1:0]    InstrCount,
    output logic                     ResultValid,
    input  logic                     ResultReady,
    output logic [`DataWidth-1:0]    ResultData,
    output logic [`RegAddrWidth-1:0] ResultDest,
    output logic [`DataWidth-1:0]    ResultCount
);

    logic                     advance;

    // Decode
    logic [`RegAddrWidth-1:0] rsAddr, rtAddr, decDest, decShamt;
    logic [`DataWidth-1:0]    rsData, rtData, decImm;
    logic                     decRegWrite, decAluSrc;
    DecodeExecutePkg::AluOpE  decAluOp;

    // ID/EX
    logic [`RegAddrWidth-1:0] exDest, exShamt, exRsReg, exRtReg;
    logic [`DataWidth-1:0]    exImm, exRsData, exRtData, exCount;
    logic                     exRegWrite, exAluSrc;
    DecodeExecutePkg::AluOpE  exAluOp;

    // Execute out, write-back and forwarding
    logic [`DataWidth-1:0]    aluResult, aluCount, wrData, fwdData;
    logic [`RegAddrWidth-1:0] aluDest, wrAddr, fwdReg;
    logic                     aluRegWrite, wrEn, fwdValid;

    // Stall only while a result is waiting to be taken
    assign advance    = !(ResultValid && !ResultReady);
    assign InstrReady = advance;

    InstructionDecoder InstructionDecoder_i (
        .InstrValid (InstrValid), .InstrWord (InstrWord),
        .RsAddr (rsAddr), .RtAddr (rtAddr),
        .RegWrite (decRegWrite), .AluSrc (decAluSrc), .AluOp (decAluOp),
        .DestReg (decDest), .Shamt (decShamt), .Imm (decImm)
    );

    RegisterFile RegisterFile_i (
        .Clock (Clock), .arstN (arstN),
        .RsAddr (rsAddr), .RtAddr (rtAddr), .RsData (rsData), .RtData (rtData),
        .WrEn (wrEn), .WrAddr (wrAddr), .WrData (wrData)
    );

    IdExReg IdExReg_i (
        .Clock (Clock), .arstN (arstN), .WriteEnable (advance),
        .RegWriteIn (decRegWrite), .AluSrcIn (decAluSrc), .AluOpIn (decAluOp),
        .DestRegIn (decDest), .ShamtIn (decShamt), .ImmIn (decImm),
        .RsRegIn (rsAddr), .RtRegIn (rtAddr), .RsDataIn (rsData), .RtDataIn (rtData),
        .CountIn (InstrCount),
        .RegWriteOut (exRegWrite), .AluSrcOut (exAluSrc), .AluOpOut (exAluOp),
        .DestRegOut (exDest), .ShamtOut (exShamt), .ImmOut (exImm),
        .RsRegOut (exRsReg), .RtRegOut (exRtReg), .RsDataOut (exRsData),
        .RtDataOut (exRtData), .CountOut (exCount)
    );

    ExecuteUnit ExecuteUnit_i (
        .RegWriteIn (exRegWrite), .AluSrc (exAluSrc), .AluOp (exAluOp),
        .DestRegIn (exDest), .Shamt (exShamt), .Imm (exImm),
        .RsReg (exRsReg), .RtReg (exRtReg), .RsData (exRsData), .RtData (exRtData),
        .CountIn (exCount),
        .FwdValid (fwdValid), .FwdReg (fwdReg), .FwdData (fwdData),
        .AluResult (aluResult), .DestReg (aluDest), .RegWrite (aluRegWrite),
        .Count (aluCount)
    );

    ResultStage ResultStage_i (
        .Clock (Clock), .arstN (arstN), .Load (advance),
        .RegWriteIn (aluRegWrite), .DestIn (aluDest), .DataIn (aluResult),
        .CountIn (aluCount),
        .ResultValid (ResultValid), .ResultDest (ResultDest), .ResultData (ResultData),
        .ResultCount (ResultCount), .ResultReady (ResultReady),
        .WrEn (wrEn), .WrAddr (wrAddr), .WrData (wrData),
        .FwdValid (fwdValid), .FwdReg (fwdReg), .FwdData (fwdData)
    );

endmodule

// File: verification/ClockGen.sv
module ClockGen (
    output logic Clock,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // Reset released just after the 16th rising edge
    initial begin
        arstN = 1'b0;
        repeat (16) @(posedge Clock);
        #10 arstN = 1'b1;
    end

endmodule

// File: verification/DecodeExecuteTb.sv
`include "decodeExecute_params.svh"

module DecodeExecuteTb #(
    parameter int CyclesPerInstr = 40,
    parameter int CycleMargin    = 200
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                     Clock;
    logic                     arstN;
    logic                     InstrValid;
    logic                     InstrReady;
    logic [`DataWidth-1:0]    InstrWord;
    logic [`DataWidth-1:0]    InstrCount;
    logic                     ResultValid;
    logic                     ResultReady;
    logic [`DataWidth-1:0]    ResultData;
    logic [`RegAddrWidth-1:0] ResultDest;
    logic [`DataWidth-1:0]    ResultCount;

    // Reference model and expected results in issue order
    logic [`DataWidth-1:0]    regModel [`RegCount];
    logic [`DataWidth-1:0]    expCount [1024];
    logic [`DataWidth-1:0]    expData [1024];
    logic [`RegAddrWidth-1:0] expDest [1024];
    int                       resultTotal = 0;
    int                       takenIdx = 0;
    int                       issueCount = 0;
    int                       errorCount = 0;
    int                       errorsAtStart = 0;
    int                       cycleCount = 0;
    int                       testsPassed = 0;
    int                       testsFailed = 0;
    logic                     stallMode = 1'b0;
    logic                     headAvail;
    logic [`DataWidth-1:0]    headCount;
    logic [`DataWidth-1:0]    headData;
    logic [`RegAddrWidth-1:0] headDest;

    assign headAvail = takenIdx < resultTotal;
    assign headCount = expCount[takenIdx[9:0]];
    assign headData  = expData[takenIdx[9:0]];
    assign headDest  = expDest[takenIdx[9:0]];

    ClockGen ClockGen_i (.Clock (Clock), .arstN (arstN));

    DecodeExecuteCore DecodeExecuteCore_i (
        .Clock (Clock), .arstN (arstN),
        .InstrValid (InstrValid), .InstrReady (InstrReady),
        .InstrWord (InstrWord), .InstrCount (InstrCount),
        .ResultValid (ResultValid), .ResultReady (ResultReady),
        .ResultData (ResultData), .ResultDest (ResultDest), .ResultCount (ResultCount)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    resultCountCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ResultValid && ResultReady) |-> (headAvail && ResultCount == headCount))
    else begin
        $display("** Error: ResultCount = %h, expected %h", $sampled(ResultCount),
                 $sampled(headCount));
        errorCount++;
    end

    resultDataCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ResultValid && ResultReady && headAvail) |-> ResultData == headData)
    else begin
        $display("** Error: ResultData = %h, expected %h", $sampled(ResultData),
                 $sampled(headData));
        errorCount++;
    end

    resultDestCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ResultValid && ResultReady && headAvail) |-> ResultDest == headDest)
    else begin
        $display("** Error: ResultDest = %h, expected %h", $sampled(ResultDest),
                 $sampled(headDest));
        errorCount++;
    end

    holdStableCheck: assert property (@(posedge Clock) disable iff (!arstN)
        (ResultValid && !ResultReady) |=>
            (ResultValid && $stable(ResultData) && $stable(ResultDest) && $stable(ResultCount)))
    else begin
        $display("A held result changed or vanished before it was taken");
        errorCount++;
    end

    readyRuleCheck: assert property (@(posedge Clock) disable iff (!arstN)
        InstrReady == !(ResultValid && !ResultReady))
    else begin
        $display("** Error: InstrReady = %h with ResultValid = %h, ResultReady = %h",
                 $sampled(InstrReady), $sampled(ResultValid), $sampled(ResultReady));
        errorCount++;
    end

    always @(posedge Clock) begin
        if (ResultValid && ResultReady) begin
            takenIdx <= takenIdx + 1;
        end
    end

    // Limit grows with every issued instruction
    initial begin : watchdog
        while (cycleCount < CyclesPerInstr * issueCount + CycleMargin) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, %0d of %0d results taken", cycleCount, takenIdx,
                 resultTotal);
        $display("TEST FAILED");
        $finish;
    end

    // Random back-pressure stretches
    initial begin : readyDriver
        int stretch;
        stretch = 0;
        ResultReady = 1'b1;
        forever begin
            @(posedge Clock);
            #10;
            if (!stallMode) begin
                stretch = 0;
            end else if (stretch == 0 && $urandom_range(2, 0) == 0) begin
                stretch = $urandom_range(6, 1);
            end
            ResultReady = (stretch == 0);
            if (stretch > 0) begin
                stretch--;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoding, reference model and drivers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encodeR(input DecodeExecutePkg::FunctE fn,
                                            input logic [4:0] rd, rs, rt, shamt);
        return {DecodeExecutePkg::OpSpecial, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encodeI(input DecodeExecutePkg::OpcodeE op,
                                            input logic [4:0] rt, rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic void modelExecute(input logic [31:0] word, output logic hasResult,
                                         output logic [4:0] dest, output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [5:0]  fn;
        a = regModel[word[25:21]];
        b = regModel[word[20:16]];
        imm = word[15:0];
        fn = word[5:0];
        hasResult = 1'b1;
        dest = word[20:16];
        value = '0;
        if (word[31:26] == DecodeExecutePkg::OpSpecial) begin
            dest = word[15:11];
            if (fn == DecodeExecutePkg::FnAddu) value = a + b;
            else if (fn == DecodeExecutePkg::FnSubu) value = a - b;
            else if (fn == DecodeExecutePkg::FnAnd) value = a & b;
            else if (fn == DecodeExecutePkg::FnOr) value = a | b;
            else if (fn == DecodeExecutePkg::FnXor) value = a ^ b;
            else if (fn == DecodeExecutePkg::FnSlt) value = {31'b0, $signed(a) < $signed(b)};
            else if (fn == DecodeExecutePkg::FnSll) value = b << word[10:6];
            else if (fn == DecodeExecutePkg::FnSrl) value = b >> word[10:6];
            else hasResult = 1'b0;
        end
        else if (word[31:26] == DecodeExecutePkg::OpAddiu) value = a + {{16{imm[15]}}, imm};
        else if (word[31:26] == DecodeExecutePkg::OpAndi) value = a & {16'h0000, imm};
        else if (word[31:26] == DecodeExecutePkg::OpOri) value = a | {16'h0000, imm};
        else if (word[31:26] == DecodeExecutePkg::OpLui) value = {imm, 16'h0000};
        else hasResult = 1'b0;
    endfunction

    function automatic logic [31:0] randomInstr(input int lo, input int hi);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] word;
        rs = 5'($urandom_range(hi, lo));
        rt = 5'($urandom_range(hi, lo));
        rd = 5'($urandom_range(hi, lo));
        imm = 16'($urandom);
        case ($urandom_range(11, 0))
            0: word = encodeR(DecodeExecutePkg::FnAddu, rd, rs, rt, 5'd0);
            1: word = encodeR(DecodeExecutePkg::FnSubu, rd, rs, rt, 5'd0);
            2: word = encodeR(DecodeExecutePkg::FnAnd, rd, rs, rt, 5'd0);
            3: word = encodeR(DecodeExecutePkg::FnOr, rd, rs, rt, 5'd0);
            4: word = encodeR(DecodeExecutePkg::FnXor, rd, rs, rt, 5'd0);
            5: word = encodeR(DecodeExecutePkg::FnSlt, rd, rs, rt, 5'd0);
            6: word = encodeR(DecodeExecutePkg::FnSll, rd, 5'd0, rt, imm[4:0]);
            7: word = encodeR(DecodeExecutePkg::FnSrl, rd, 5'd0, rt, imm[4:0]);
            8: word = encodeI(DecodeExecutePkg::OpAddiu, rt, rs, imm);
            9: word = encodeI(DecodeExecutePkg::OpAndi, rt, rs, imm);
            10: word = encodeI(DecodeExecutePkg::OpOri, rt, rs, imm);
            default: word = encodeI(DecodeExecutePkg::OpLui, rt, 5'd0, imm);
        endcase
        return word;
    endfunction

    // Called 10 ns after an edge; returns 10 ns after the accept edge
    task automatic issue(input logic [31:0] word);
        logic        hasResult;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        accepted;
        modelExecute(word, hasResult, dest, value);
        if (hasResult) begin
            expCount[resultTotal] = issueCount;
            expDest[resultTotal] = dest;
            expData[resultTotal] = value;
            resultTotal++;
            if (dest != 5'd0) begin
                regModel[dest] = value;
            end
        end
        InstrValid = 1'b1;
        InstrWord = word;
        InstrCount = issueCount;
        accepted = 1'b0;
        while (!accepted) begin
            // Ready is settled by mid-cycle
            @(negedge Clock);
            accepted = InstrReady;
            @(posedge Clock);
            #10;
        end
        InstrValid = 1'b0;
        issueCount++;
    endtask

    task automatic loadConst(input logic [4:0] r, input logic [31:0] value);
        issue(encodeI(DecodeExecutePkg::OpLui, r, 5'd0, value[31:16]));
        issue(encodeI(DecodeExecutePkg::OpOri, r, r, value[15:0]));
    endtask

    task automatic finishTest(input string name);
        stallMode = 1'b0;
        while (takenIdx < resultTotal) begin
            @(posedge Clock);
        end
        // Two-cycle latency, so a stray result would show up here
        repeat (4) @(posedge Clock);
        #10;
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("%s: PASS", name);
        end else begin
            testsFailed++;
            $display("%s: FAIL with %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        InstrValid = 1'b0;
        InstrWord = '0;
        InstrCount = '0;
        for (int i = 0; i < `RegCount; i++) begin
            regModel[i] = '0;
        end
        void'($urandom(32'ha20ec770));
        @(posedge arstN);
        resetStateCheck: assert (!ResultValid && InstrReady) else begin
            $display("** Error: ResultValid = %h, InstrReady = %h after reset", ResultValid,
                     InstrReady);
            errorCount++;
        end
        finishTest("reset state");

        loadConst(5'd1, 32'h8765_4321);
        loadConst(5'd2, 32'h1234_5678);
        loadConst(5'd3, 32'hffff_fff0);
        issue(encodeR(DecodeExecutePkg::FnAddu, 5'd5, 5'd1, 5'd2, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnSubu, 5'd6, 5'd2, 5'd1, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnAnd, 5'd7, 5'd1, 5'd2, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnOr, 5'd8, 5'd1, 5'd3, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnXor, 5'd9, 5'd2, 5'd3, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnSlt, 5'd10, 5'd1, 5'd2, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnSlt, 5'd11, 5'd2, 5'd3, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnSll, 5'd12, 5'd0, 5'd2, 5'd7));
        issue(encodeR(DecodeExecutePkg::FnSrl, 5'd13, 5'd0, 5'd1, 5'd9));
        repeat (16) issue(randomInstr(1, 13));
        finishTest("ALU operations");

        issue(encodeI(DecodeExecutePkg::OpAddiu, 5'd14, 5'd2, 16'hfff0));
        issue(encodeI(DecodeExecutePkg::OpAndi, 5'd15, 5'd3, 16'h8f0f));
        issue(encodeI(DecodeExecutePkg::OpOri, 5'd16, 5'd0, 16'h8001));
        issue(encodeI(DecodeExecutePkg::OpAddiu, 5'd17, 5'd0, 16'h8000));
        finishTest("immediate extension");

        issue(encodeI(DecodeExecutePkg::OpAddiu, 5'd20, 5'd0, 16'd7));
        issue(encodeR(DecodeExecutePkg::FnAddu, 5'd21, 5'd20, 5'd20, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnSubu, 5'd22, 5'd21, 5'd20, 5'd0));
        issue(encodeR(DecodeExecutePkg::FnXor, 5'd20, 5'd22, 5'd21, 5'd0));
        repeat (24) issue(randomInstr(20, 23));
        finishTest("forwarding and write-through");

        stallMode = 1'b1;
        repeat (40) issue(randomInstr(1, 8));
        finishTest("back-pressure");

        issue({6'h23, 5'd1, 5'd4, 16'h0010});
        issue(encodeI(DecodeExecutePkg::OpAddiu, 5'd0, 5'd0, 16'h0055));
        issue(encodeR(DecodeExecutePkg::FnAddu, 5'd24, 5'd0, 5'd0, 5'd0));
        issue({6'h00, 5'd1, 5'd0, 5'd0, 5'd0, 6'h08});
        issue(encodeR(DecodeExecutePkg::FnOr, 5'd25, 5'd0, 5'd1, 5'd0));
        finishTest("bubbles and register 0");

        $display("Tests: %0d passed, %0d failed, %0d errors, %0d results taken",
                 testsPassed, testsFailed, errorCount, takenIdx);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
source/DecodeExecutePkg.sv
source/InstructionDecoder.sv
source/RegisterFile.sv
source/IdExReg.sv
source/ExecuteUnit.sv
source/ResultStage.sv
source/DecodeExecuteCore.sv
verification/ClockGen.sv
verification/DecodeExecuteTb.sv

// File: Makefile
# Verilator build and run of the decode/execute testbench
VERILATOR        ?= verilator
TOP              ?= DecodeExecuteTb
LOG              ?= sim.log
CYCLES_PER_INSTR ?= 40
BUILD_DIR        ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG CYCLES_PER_INSTR BUILD_DIR"

test:
	$(VERILATOR) --binary --timing --assert --timescale 1ns/100ps \
		-f compile.f --top-module $(TOP) -GCyclesPerInstr=$(CYCLES_PER_INSTR) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
